/* riscv_soc_fabric.f */
source/soc_map_pkg.sv
source/soc_bus_pkg.sv
source/sram_bank.sv
source/apb_bridge.sv
source/gpio_regs.sv
source/bus_ctrl.sv
source/soc_fabric_top.sv
verif/soc_fabric_chk.sv
verif/soc_fabric_tb.sv

/* verif/soc_fabric_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module soc_fabric_tb;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 3;
  localparam int XFER_COUNT   = 56;
  localparam int WDOG_CYCLES  = XFER_COUNT * 10 + RESET_CYCLES;
  localparam int DW           = soc_map_pkg::DATA_W;
  localparam int AW           = soc_map_pkg::ADDR_W;

  logic                           core_clk;
  logic                           reset_n;
  logic                           req_i;
  soc_bus_pkg::bus_req_t          req_data;
  logic                           ready;
  logic                           done;
  soc_bus_pkg::bus_rsp_t          rsp;
  logic [soc_map_pkg::GPIO_W-1:0] gpio_in;
  logic [soc_map_pkg::GPIO_W-1:0] gpio_out;
  logic [soc_map_pkg::GPIO_W-1:0] gpio_dir;
  logic [31:0]                    rng_state;

  soc_fabric_top uut (
    .core_clk   (core_clk),
    .reset_n    (reset_n),
    .req_i      (req_i),
    .req_data_i (req_data),
    .ready_o    (ready),
    .done_o     (done),
    .rsp_o      (rsp),
    .gpio_in_i  (gpio_in),
    .gpio_out_o (gpio_out),
    .gpio_dir_o (gpio_dir)
  );

  always #(CLK_PERIOD / 2) core_clk = ~core_clk;

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_rsp(input string name, input soc_bus_pkg::bus_rsp_t exp,
                           input soc_bus_pkg::bus_rsp_t act);
    if (act !== exp) begin
      stop_run($sformatf("FAILED t=%0t %s expected rdata=%h err=%b actual rdata=%h err=%b",
                         $time, name, exp.rdata, exp.err, act.rdata, act.err));
    end
  endtask

  task automatic check_pins(input string name, input logic [soc_map_pkg::GPIO_W-1:0] exp,
                            input logic [soc_map_pkg::GPIO_W-1:0] act);
    if (act !== exp) begin
      stop_run($sformatf("FAILED t=%0t %s expected %h actual %h", $time, name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_run($sformatf("FAILED t=%0t %s expected %b actual %b", $time, name, exp, act));
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (act != exp) begin
      stop_run($sformatf("FAILED t=%0t %s expected %0d actual %0d", $time, name, exp, act));
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic soc_bus_pkg::bus_rsp_t make_rsp(input logic [DW-1:0] rdata, input logic err);
    soc_bus_pkg::bus_rsp_t r;
    r.rdata = rdata;
    r.err   = err;
    return r;
  endfunction

  // lat counts rising edges from acceptance to done_o
  task automatic run_transfer(input soc_bus_pkg::bus_req_t req,
                              output soc_bus_pkg::bus_rsp_t got, output int lat);
    @(negedge core_clk);
    while (!ready) begin
      @(negedge core_clk);
    end
    req_i    = 1'b1;
    req_data = req;
    @(negedge core_clk);
    req_i = 1'b0;
    lat   = 0;
    check_flag("ready_o", 1'b0, ready);
    while (!done) begin
      @(negedge core_clk);
      lat++;
      check_flag("ready_o", 1'b0, ready);
    end
    got = rsp;
    // ready comes back one cycle after done
    @(negedge core_clk);
    check_flag("ready_o", 1'b1, ready);
  endtask

  task automatic bus_write(input logic [AW-1:0] addr, input logic [DW-1:0] data,
                           output soc_bus_pkg::bus_rsp_t got, output int lat);
    soc_bus_pkg::bus_req_t req;
    req.we    = 1'b1;
    req.addr  = addr;
    req.wdata = data;
    run_transfer(req, got, lat);
  endtask

  task automatic bus_read(input logic [AW-1:0] addr,
                          output soc_bus_pkg::bus_rsp_t got, output int lat);
    soc_bus_pkg::bus_req_t req;
    req.we    = 1'b0;
    req.addr  = addr;
    req.wdata = '0;
    run_transfer(req, got, lat);
  endtask

  task automatic test_sram_latency();
    soc_bus_pkg::bus_rsp_t got;
    int                    lat;
    bus_write(soc_map_pkg::IRAM_BASE + 32'h10, 32'hC0DE_0010, got, lat);
    check_rsp("rsp_o", make_rsp('0, 1'b0), got);
    check_latency("sram write latency", 2, lat);
    bus_read(soc_map_pkg::IRAM_BASE + 32'h10, got, lat);
    check_rsp("rsp_o", make_rsp(32'hC0DE_0010, 1'b0), got);
    check_latency("sram read latency", 2, lat);
  endtask

  task automatic test_bank_separation();
    soc_bus_pkg::bus_rsp_t got;
    int                    lat;
    bus_write(soc_map_pkg::IRAM_BASE + 32'h20, 32'h1111_2222, got, lat);
    bus_write(soc_map_pkg::DRAM_BASE + 32'h20, 32'h3333_4444, got, lat);
    bus_read(soc_map_pkg::IRAM_BASE + 32'h20, got, lat);
    check_rsp("rsp_o", make_rsp(32'h1111_2222, 1'b0), got);
    bus_read(soc_map_pkg::DRAM_BASE + 32'h20, got, lat);
    check_rsp("rsp_o", make_rsp(32'h3333_4444, 1'b0), got);
  endtask

  task automatic test_gpio_outputs();
    soc_bus_pkg::bus_rsp_t got;
    int                    lat;
    bus_write(soc_map_pkg::APB_BASE + soc_map_pkg::GPIO_OUT, 32'h9, got, lat);
    check_rsp("rsp_o", make_rsp('0, 1'b0), got);
    check_latency("apb write latency", 4, lat);
    check_pins("gpio_out_o", 4'h9, gpio_out);
    bus_write(soc_map_pkg::APB_BASE + soc_map_pkg::GPIO_DIR, 32'h6, got, lat);
    check_pins("gpio_dir_o", 4'h6, gpio_dir);
    bus_read(soc_map_pkg::APB_BASE + soc_map_pkg::GPIO_OUT, got, lat);
    check_rsp("rsp_o", make_rsp(32'h9, 1'b0), got);
    bus_read(soc_map_pkg::APB_BASE + soc_map_pkg::GPIO_DIR, got, lat);
    check_rsp("rsp_o", make_rsp(32'h6, 1'b0), got);
  endtask

  task automatic test_gpio_input();
    soc_bus_pkg::bus_rsp_t got;
    int                    lat;
    @(negedge core_clk);
    gpio_in = 4'hA;
    // let the two sync flops settle
    repeat (3) @(negedge core_clk);
    bus_read(soc_map_pkg::APB_BASE + soc_map_pkg::GPIO_IN, got, lat);
    check_rsp("rsp_o", make_rsp(32'hA, 1'b0), got);
    bus_write(soc_map_pkg::APB_BASE + soc_map_pkg::GPIO_IN, 32'h5, got, lat);
    check_rsp("rsp_o", make_rsp('0, 1'b0), got);
    bus_read(soc_map_pkg::APB_BASE + soc_map_pkg::GPIO_IN, got, lat);
    check_rsp("rsp_o", make_rsp(32'hA, 1'b0), got);
  endtask

  task automatic test_error_responses();
    soc_bus_pkg::bus_rsp_t got;
    int                    lat;
    bus_read(32'h2000_0000, got, lat);
    check_rsp("rsp_o", make_rsp('0, 1'b1), got);
    check_latency("unmapped latency", 1, lat);
    bus_read(soc_map_pkg::APB_BASE + 32'hC, got, lat);
    check_rsp("rsp_o", make_rsp('0, 1'b1), got);
    bus_read(soc_map_pkg::IRAM_BASE + 32'h10, got, lat);
    check_rsp("rsp_o", make_rsp(32'hC0DE_0010, 1'b0), got);
  endtask

  task automatic test_random_traffic();
    logic [DW-1:0]         model [2][16];
    bit                    valid [2][16];
    logic [31:0]           r;
    logic [AW-1:0]         addr;
    int                    bank;
    int                    idx;
    int                    lat;
    soc_bus_pkg::bus_rsp_t got;
    for (int b = 0; b < 2; b++) begin
      for (int i = 0; i < 16; i++) begin
        valid[b][i] = 1'b0;
      end
    end
    for (int n = 0; n < 40; n++) begin
      rng_state = xorshift32(rng_state);
      r    = rng_state;
      bank = int'(r[4]);
      idx  = int'(r[3:0]);
      addr = (bank == 0 ? soc_map_pkg::IRAM_BASE : soc_map_pkg::DRAM_BASE) + 32'(idx * 4);
      // never read a word the model has not seen written
      if (r[5] || !valid[bank][idx]) begin
        rng_state = xorshift32(rng_state);
        bus_write(addr, rng_state, got, lat);
        check_rsp("rsp_o", make_rsp('0, 1'b0), got);
        model[bank][idx] = rng_state;
        valid[bank][idx] = 1'b1;
      end else begin
        bus_read(addr, got, lat);
        check_rsp("rsp_o", make_rsp(model[bank][idx], 1'b0), got);
      end
      check_latency("sram latency", 2, lat);
    end
  endtask

  initial begin
    core_clk  = 1'b0;
    reset_n   = 1'b0;
    req_i     = 1'b0;
    req_data  = '0;
    gpio_in   = '0;
    rng_state = 32'd14;
    repeat (RESET_CYCLES) @(posedge core_clk);
    @(negedge core_clk);
    reset_n = 1'b1;
    check_flag("ready_o", 1'b1, ready);
    check_flag("done_o", 1'b0, done);
    check_pins("gpio_out_o", '0, gpio_out);
    check_pins("gpio_dir_o", '0, gpio_dir);
    test_sram_latency();
    test_bank_separation();
    test_gpio_outputs();
    test_gpio_input();
    test_error_responses();
    test_random_traffic();
    if (uut.u_chk.fail_cnt == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      stop_run("bus protocol assertion failed during the run");
    end
  end

  // stop at the first bound assertion failure
  always @(negedge core_clk) begin
    if (uut.u_chk.fail_cnt != 0) begin
      stop_run("bus protocol assertion failed");
    end
  end

  initial begin
    repeat (WDOG_CYCLES) @(posedge core_clk);
    stop_run("watchdog expired, the run hung");
  end

endmodule

`default_nettype wire

/* verif/soc_fabric_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module soc_fabric_chk (
  input wire                         core_clk,
  input wire                         reset_n,
  input wire                         req_i,
  input wire                         ready_i,
  input wire                         done_i,
  input wire soc_bus_pkg::bus_rsp_t  rsp_i
);

  int unsigned fail_cnt = 0;

  // done is a single-cycle pulse
  done_pulse: assert property (@(posedge core_clk) disable iff (!reset_n)
    done_i |=> !done_i)
    else begin
      fail_cnt++;
      $error("done_o high for two cycles");
    end

  done_not_ready: assert property (@(posedge core_clk) disable iff (!reset_n)
    done_i |-> !ready_i)
    else begin
      fail_cnt++;
      $error("ready_o high together with done_o");
    end

  // no transfer starting, so the response must hold
  rsp_hold: assert property (@(posedge core_clk) disable iff (!reset_n)
    (ready_i && !req_i) |=> $stable(rsp_i))
    else begin
      fail_cnt++;
      $error("rsp_o changed while idle");
    end

endmodule

bind soc_fabric_top soc_fabric_chk u_chk (
  .core_clk (core_clk),
  .reset_n  (reset_n),
  .req_i    (req_i),
  .ready_i  (ready_o),
  .done_i   (done_o),
  .rsp_i    (rsp_o)
);

`default_nettype wire

/* source/soc_fabric_top.sv */
`timescale 1ns/10ps
`default_nettype none

module soc_fabric_top (
  input  wire                                core_clk,
  input  wire                                reset_n,
  input  wire                                req_i,
  input  wire soc_bus_pkg::bus_req_t         req_data_i,
  output logic                               ready_o,
  output logic                               done_o,
  output soc_bus_pkg::bus_rsp_t              rsp_o,
  input  wire [soc_map_pkg::GPIO_W-1:0]      gpio_in_i,
  output logic [soc_map_pkg::GPIO_W-1:0]     gpio_out_o,
  output logic [soc_map_pkg::GPIO_W-1:0]     gpio_dir_o
);

  soc_bus_pkg::sram_cmd_t            iram_cmd;
  soc_bus_pkg::sram_cmd_t            dram_cmd;
  logic [soc_map_pkg::DATA_W-1:0]    iram_rdata;
  logic [soc_map_pkg::DATA_W-1:0]    dram_rdata;
  logic                              apb_start;
  logic                              apb_we;
  logic [soc_map_pkg::PADDR_W-1:0]   apb_addr;
  logic [soc_map_pkg::DATA_W-1:0]    apb_wdata;
  logic                              apb_done;
  soc_bus_pkg::apb_rsp_t             apb_rsp;
  soc_bus_pkg::apb_req_t             apb_req;
  soc_bus_pkg::apb_rsp_t             gpio_rsp;
  logic                              gpio_pready;

  bus_ctrl u_bus_ctrl (
    .core_clk     (core_clk),
    .reset_n      (reset_n),
    .req_i        (req_i),
    .req_data_i   (req_data_i),
    .ready_o      (ready_o),
    .done_o       (done_o),
    .rsp_o        (rsp_o),
    .iram_cmd_o   (iram_cmd),
    .dram_cmd_o   (dram_cmd),
    .iram_rdata_i (iram_rdata),
    .dram_rdata_i (dram_rdata),
    .apb_start_o  (apb_start),
    .apb_we_o     (apb_we),
    .apb_addr_o   (apb_addr),
    .apb_wdata_o  (apb_wdata),
    .apb_done_i   (apb_done),
    .apb_rsp_i    (apb_rsp)
  );

  sram_bank u_iram (
    .core_clk (core_clk),
    .cmd_i    (iram_cmd),
    .rdata_o  (iram_rdata)
  );

  sram_bank u_dram (
    .core_clk (core_clk),
    .cmd_i    (dram_cmd),
    .rdata_o  (dram_rdata)
  );

  apb_bridge u_apb_bridge (
    .core_clk (core_clk),
    .reset_n  (reset_n),
    .start_i  (apb_start),
    .we_i     (apb_we),
    .addr_i   (apb_addr),
    .wdata_i  (apb_wdata),
    .done_o   (apb_done),
    .rsp_o    (apb_rsp),
    .apb_o    (apb_req),
    .apb_i    (gpio_rsp),
    .pready_i (gpio_pready)
  );

  gpio_regs u_gpio (
    .core_clk   (core_clk),
    .reset_n    (reset_n),
    .apb_i      (apb_req),
    .apb_o      (gpio_rsp),
    .pready_o   (gpio_pready),
    .gpio_in_i  (gpio_in_i),
    .gpio_out_o (gpio_out_o),
    .gpio_dir_o (gpio_dir_o)
  );

endmodule

`default_nettype wire

/* source/bus_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module bus_ctrl (
  input  wire                              core_clk,
  input  wire                              reset_n,
  input  wire                              req_i,
  input  wire soc_bus_pkg::bus_req_t       req_data_i,
  output logic                             ready_o,
  output logic                             done_o,
  output soc_bus_pkg::bus_rsp_t            rsp_o,
  output soc_bus_pkg::sram_cmd_t           iram_cmd_o,
  output soc_bus_pkg::sram_cmd_t           dram_cmd_o,
  input  wire [soc_map_pkg::DATA_W-1:0]    iram_rdata_i,
  input  wire [soc_map_pkg::DATA_W-1:0]    dram_rdata_i,
  output logic                             apb_start_o,
  output logic                             apb_we_o,
  output logic [soc_map_pkg::PADDR_W-1:0]  apb_addr_o,
  output logic [soc_map_pkg::DATA_W-1:0]   apb_wdata_o,
  input  wire                              apb_done_i,
  input  wire soc_bus_pkg::apb_rsp_t       apb_rsp_i
);

  soc_bus_pkg::bus_state_e  state_q;
  soc_map_pkg::slave_sel_e  sel_d;
  soc_map_pkg::slave_sel_e  sel_q;
  soc_bus_pkg::bus_req_t    req_q;
  soc_bus_pkg::bus_rsp_t    rsp_d;
  soc_bus_pkg::sram_cmd_t   ram_cmd;
  logic                     accept;

  // idle and not in the done cycle
  assign ready_o = (state_q == soc_bus_pkg::ST_IDLE) && !done_o;
  assign accept  = req_i && ready_o;

  // base/mask match on the incoming address
  always_comb begin
    if ((req_data_i.addr & soc_map_pkg::IRAM_MASK) == soc_map_pkg::IRAM_BASE) begin
      sel_d = soc_map_pkg::SLV_IRAM;
    end else if ((req_data_i.addr & soc_map_pkg::DRAM_MASK) == soc_map_pkg::DRAM_BASE) begin
      sel_d = soc_map_pkg::SLV_DRAM;
    end else if ((req_data_i.addr & soc_map_pkg::APB_MASK) == soc_map_pkg::APB_BASE) begin
      sel_d = soc_map_pkg::SLV_APB;
    end else begin
      sel_d = soc_map_pkg::SLV_NONE;
    end
  end

  always_ff @(posedge core_clk) begin
    if (accept) begin
      req_q <= req_data_i;
    end
  end

  always_ff @(posedge core_clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q     <= soc_bus_pkg::ST_IDLE;
      sel_q       <= soc_map_pkg::SLV_NONE;
      done_o      <= 1'b0;
      apb_start_o <= 1'b0;
      rsp_o       <= '0;
    end else begin
      done_o      <= 1'b0;
      apb_start_o <= 1'b0;
      case (state_q)
        soc_bus_pkg::ST_IDLE: begin
          if (accept) begin
            sel_q <= sel_d;
            case (sel_d)
              soc_map_pkg::SLV_IRAM,
              soc_map_pkg::SLV_DRAM: state_q <= soc_bus_pkg::ST_SRAM;
              soc_map_pkg::SLV_APB: begin
                state_q     <= soc_bus_pkg::ST_APB;
                apb_start_o <= 1'b1;
              end
              default: state_q <= soc_bus_pkg::ST_DONE;
            endcase
          end
        end
        // bank acts on this edge, read data follows
        soc_bus_pkg::ST_SRAM: state_q <= soc_bus_pkg::ST_DONE;
        soc_bus_pkg::ST_APB: begin
          if (apb_done_i) begin
            done_o  <= 1'b1;
            rsp_o   <= rsp_d;
            state_q <= soc_bus_pkg::ST_IDLE;
          end
        end
        default: begin
          done_o  <= 1'b1;
          rsp_o   <= rsp_d;
          state_q <= soc_bus_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // response steering
  always_comb begin
    rsp_d = '0;
    case (sel_q)
      soc_map_pkg::SLV_IRAM: rsp_d.rdata = iram_rdata_i;
      soc_map_pkg::SLV_DRAM: rsp_d.rdata = dram_rdata_i;
      soc_map_pkg::SLV_APB: begin
        rsp_d.rdata = apb_rsp_i.prdata;
        rsp_d.err   = apb_rsp_i.pslverr;
      end
      default: rsp_d.err = 1'b1;
    endcase
    // writes return zero data
    if (req_q.we) begin
      rsp_d.rdata = '0;
    end
  end

  always_comb begin
    ram_cmd.en    = (state_q == soc_bus_pkg::ST_SRAM);
    ram_cmd.we    = req_q.we;
    ram_cmd.index = req_q.addr[soc_map_pkg::RAM_IDX_W+1:2];
    ram_cmd.wdata = req_q.wdata;
    iram_cmd_o    = ram_cmd;
    dram_cmd_o    = ram_cmd;
    iram_cmd_o.en = ram_cmd.en && (sel_q == soc_map_pkg::SLV_IRAM);
    dram_cmd_o.en = ram_cmd.en && (sel_q == soc_map_pkg::SLV_DRAM);
  end

  assign apb_we_o    = req_q.we;
  assign apb_addr_o  = req_q.addr[soc_map_pkg::PADDR_W-1:0];
  assign apb_wdata_o = req_q.wdata;

endmodule

`default_nettype wire

/* source/gpio_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module gpio_regs (
  input  wire                              core_clk,
  input  wire                              reset_n,
  input  wire soc_bus_pkg::apb_req_t       apb_i,
  output soc_bus_pkg::apb_rsp_t            apb_o,
  output logic                             pready_o,
  input  wire [soc_map_pkg::GPIO_W-1:0]    gpio_in_i,
  output logic [soc_map_pkg::GPIO_W-1:0]   gpio_out_o,
  output logic [soc_map_pkg::GPIO_W-1:0]   gpio_dir_o
);

  logic [soc_map_pkg::GPIO_W-1:0] in_meta;
  logic [soc_map_pkg::GPIO_W-1:0] in_sync;
  logic                           wr_en;

  assign wr_en    = apb_i.psel && apb_i.penable && apb_i.pwrite;
  assign pready_o = apb_i.psel && apb_i.penable;

  // two flop input sync
  always_ff @(posedge core_clk or negedge reset_n) begin
    if (!reset_n) begin
      in_meta <= '0;
      in_sync <= '0;
    end else begin
      in_meta <= gpio_in_i;
      in_sync <= in_meta;
    end
  end

  always_ff @(posedge core_clk or negedge reset_n) begin
    if (!reset_n) begin
      gpio_out_o <= '0;
      gpio_dir_o <= '0;
    end else if (wr_en) begin
      case (apb_i.paddr)
        soc_map_pkg::GPIO_OUT: gpio_out_o <= apb_i.pwdata[soc_map_pkg::GPIO_W-1:0];
        soc_map_pkg::GPIO_DIR: gpio_dir_o <= apb_i.pwdata[soc_map_pkg::GPIO_W-1:0];
        default: ;
      endcase
    end
  end

  // read mux, unknown offsets flag an error
  always_comb begin
    apb_o = '0;
    case (apb_i.paddr)
      soc_map_pkg::GPIO_OUT: apb_o.prdata[soc_map_pkg::GPIO_W-1:0] = gpio_out_o;
      soc_map_pkg::GPIO_DIR: apb_o.prdata[soc_map_pkg::GPIO_W-1:0] = gpio_dir_o;
      soc_map_pkg::GPIO_IN:  apb_o.prdata[soc_map_pkg::GPIO_W-1:0] = in_sync;
      default:               apb_o.pslverr = apb_i.psel;
    endcase
  end

endmodule

`default_nettype wire

/* source/apb_bridge.sv */
`timescale 1ns/10ps
`default_nettype none

module apb_bridge (
  input  wire                              core_clk,
  input  wire                              reset_n,
  input  wire                              start_i,
  input  wire                              we_i,
  input  wire [soc_map_pkg::PADDR_W-1:0]   addr_i,
  input  wire [soc_map_pkg::DATA_W-1:0]    wdata_i,
  output logic                             done_o,
  output soc_bus_pkg::apb_rsp_t            rsp_o,
  output soc_bus_pkg::apb_req_t            apb_o,
  input  wire soc_bus_pkg::apb_rsp_t       apb_i,
  input  wire                              pready_i
);

  logic access;
  logic finish;

  assign access = apb_o.psel && apb_o.penable;
  assign finish = access && pready_i;

  always_ff @(posedge core_clk or negedge reset_n) begin
    if (!reset_n) begin
      apb_o  <= '0;
      done_o <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i && !apb_o.psel) begin
        // setup phase
        apb_o.psel    <= 1'b1;
        apb_o.penable <= 1'b0;
        apb_o.pwrite  <= we_i;
        apb_o.paddr   <= addr_i;
        apb_o.pwdata  <= wdata_i;
      end else if (apb_o.psel && !apb_o.penable) begin
        apb_o.penable <= 1'b1;
      end else if (finish) begin
        apb_o.psel    <= 1'b0;
        apb_o.penable <= 1'b0;
        done_o        <= 1'b1;
      end
    end
  end

  // hold slave return for the controller
  always_ff @(posedge core_clk) begin
    if (finish) begin
      rsp_o <= apb_i;
    end
  end

endmodule

`default_nettype wire

/* source/sram_bank.sv */
`timescale 1ns/10ps
`default_nettype none

module sram_bank (
  input  wire                            core_clk,
  input  wire soc_bus_pkg::sram_cmd_t    cmd_i,
  output logic [soc_map_pkg::DATA_W-1:0] rdata_o
);

  logic [soc_map_pkg::DATA_W-1:0] mem [soc_map_pkg::RAM_WORDS];

  // single port, read data registered one cycle after the command
  always_ff @(posedge core_clk) begin
    if (cmd_i.en) begin
      if (cmd_i.we) begin
        mem[cmd_i.index] <= cmd_i.wdata;
      end else begin
        rdata_o <= mem[cmd_i.index];
      end
    end
  end

endmodule

`default_nettype wire

/* source/soc_bus_pkg.sv */
`default_nettype none

package soc_bus_pkg;

  // request from the external master port
  typedef struct packed {
    logic                           we;
    logic [soc_map_pkg::ADDR_W-1:0] addr;
    logic [soc_map_pkg::DATA_W-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic [soc_map_pkg::DATA_W-1:0] rdata;
    logic                           err;
  } bus_rsp_t;

  // word-wide sram access
  typedef struct packed {
    logic                              en;
    logic                              we;
    logic [soc_map_pkg::RAM_IDX_W-1:0] index;
    logic [soc_map_pkg::DATA_W-1:0]    wdata;
  } sram_cmd_t;

  typedef struct packed {
    logic                            psel;
    logic                            penable;
    logic                            pwrite;
    logic [soc_map_pkg::PADDR_W-1:0] paddr;
    logic [soc_map_pkg::DATA_W-1:0]  pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [soc_map_pkg::DATA_W-1:0] prdata;
    logic                           pslverr;
  } apb_rsp_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SRAM,
    ST_APB,
    ST_DONE
  } bus_state_e;

endpackage

`default_nettype wire

/* source/soc_map_pkg.sv */
`default_nettype none

package soc_map_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // slave windows, end address inclusive
  localparam logic [ADDR_W-1:0] IRAM_BASE = 32'h1A00_0000;
  localparam logic [ADDR_W-1:0] IRAM_END  = 32'h1A00_03FF;
  localparam logic [ADDR_W-1:0] DRAM_BASE = 32'h1A01_0000;
  localparam logic [ADDR_W-1:0] DRAM_END  = 32'h1A01_03FF;
  localparam logic [ADDR_W-1:0] APB_BASE  = 32'h1A10_0000;
  localparam logic [ADDR_W-1:0] APB_END   = 32'h1A10_0FFF;

  // mask = ~(end - base)
  localparam logic [ADDR_W-1:0] IRAM_MASK = ~(IRAM_END - IRAM_BASE);
  localparam logic [ADDR_W-1:0] DRAM_MASK = ~(DRAM_END - DRAM_BASE);
  localparam logic [ADDR_W-1:0] APB_MASK  = ~(APB_END - APB_BASE);

  localparam int RAM_WORDS = 256;
  localparam int RAM_IDX_W = $clog2(RAM_WORDS);
  localparam int PADDR_W   = 12;
  localparam int GPIO_W    = 4;

  typedef enum logic [1:0] {
    SLV_IRAM,
    SLV_DRAM,
    SLV_APB,
    SLV_NONE
  } slave_sel_e;

  typedef enum logic [PADDR_W-1:0] {
    GPIO_OUT = 12'h000,
    GPIO_DIR = 12'h004,
    GPIO_IN  = 12'h008
  } gpio_reg_e;

endpackage

`default_nettype wire
